//--- src/capture_control.sv
`timescale 1ns/1ns
`default_nettype none

module capture_control #(
    parameter int DEPTH_LOG2 = 8
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           command_strobe,
    input  var  capture_pkg::capture_cmd_e command,
    input  wire                           trig_hit,
    input  wire  [7:0]                    post_count,
    input  wire  [DEPTH_LOG2-1:0]         wr_ptr,
    output logic                          wr_en,
    output logic [DEPTH_LOG2-1:0]         read_addr,
    output capture_pkg::capture_state_e   state,
    output capture_pkg::capture_status_t  status,
    output logic [7:0]                    read_index,
    output logic [7:0]                    stored_count,
    output logic [7:0]                    pre_count,
    output logic [7:0]                    capture_seq
);

    // Counts need one extra bit to hold a full buffer
    localparam int count_w = DEPTH_LOG2 + 1;
    localparam logic [count_w-1:0] depth = count_w'(1 << DEPTH_LOG2);

    logic                  arm_cmd;
    logic                  abort_cmd;
    logic                  read_reset_cmd;
    logic                  read_next_cmd;
    logic                  arm_go;
    logic                  armed_d;
    logic [count_w-1:0]    fill_q;
    logic [count_w-1:0]    post_ext;
    logic [count_w-1:0]    pre_limit;
    logic [count_w-1:0]    pre_sat;
    logic [count_w-1:0]    stored_q;
    logic [count_w-1:0]    next_idx;
    logic [DEPTH_LOG2-1:0] post_left_q;
    logic [DEPTH_LOG2-1:0] pre_q;
    logic [DEPTH_LOG2-1:0] read_idx_q;
    logic                  wrapped_q;

    ////////////////////////////////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////////////////////////////////

    assign arm_cmd        = command_strobe && (command == capture_pkg::cmd_arm);
    assign abort_cmd      = command_strobe && (command == capture_pkg::cmd_abort);
    assign read_reset_cmd = command_strobe && (command == capture_pkg::cmd_read_reset);
    assign read_next_cmd  = command_strobe && (command == capture_pkg::cmd_read_next);

    // Arm is ignored while a capture is running
    assign arm_go = arm_cmd &&
                    ((state == capture_pkg::st_idle) || (state == capture_pkg::st_done));

    ////////////////////////////////////////////////////////////////////////////
    // Capture state machine
    ////////////////////////////////////////////////////////////////////////////

    // Room left in front of the trigger sample and its post samples
    assign post_ext  = count_w'(post_count);
    assign pre_limit = depth - 1'b1 - post_ext;
    assign pre_sat   = (fill_q > pre_limit) ? pre_limit : fill_q;

    // First armed cycle holds a sample that was never judged, so skip it
    assign wr_en = ((state == capture_pkg::st_armed) && armed_d) ||
                   (state == capture_pkg::st_triggered);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= capture_pkg::st_idle;
            armed_d     <= 1'b0;
            fill_q      <= '0;
            post_left_q <= '0;
            pre_q       <= '0;
            stored_q    <= '0;
            wrapped_q   <= 1'b0;
            capture_seq <= '0;
        end else begin
            armed_d <= (state == capture_pkg::st_armed);
            if (abort_cmd) begin
                state <= capture_pkg::st_idle;
            end else begin
                case (state)
                    capture_pkg::st_idle, capture_pkg::st_done: begin
                        if (arm_go) begin
                            state     <= capture_pkg::st_armed;
                            fill_q    <= '0;
                            pre_q     <= '0;
                            stored_q  <= '0;
                            wrapped_q <= 1'b0;
                        end
                    end
                    capture_pkg::st_armed: begin
                        if (trig_hit) begin
                            // Trigger sample is written in this cycle
                            pre_q       <= DEPTH_LOG2'(pre_sat);
                            stored_q    <= pre_sat + post_ext + 1'b1;
                            wrapped_q   <= (fill_q > pre_limit);
                            post_left_q <= DEPTH_LOG2'(post_count);
                            if (post_count == 8'd0) begin
                                state       <= capture_pkg::st_done;
                                capture_seq <= capture_seq + 1'b1;
                            end else begin
                                state <= capture_pkg::st_triggered;
                            end
                        end else if (wr_en && (fill_q != depth)) begin
                            fill_q <= fill_q + 1'b1;
                        end
                    end
                    capture_pkg::st_triggered: begin
                        post_left_q <= post_left_q - 1'b1;
                        if (post_left_q == DEPTH_LOG2'(1)) begin
                            state       <= capture_pkg::st_done;
                            capture_seq <= capture_seq + 1'b1;
                        end
                    end
                    default: begin
                        state <= capture_pkg::st_idle;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read-back indexing
    ////////////////////////////////////////////////////////////////////////////

    assign next_idx = {1'b0, read_idx_q} + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_idx_q <= '0;
        end else if (arm_go || read_reset_cmd) begin
            read_idx_q <= '0;
        end else if (read_next_cmd) begin
            if (next_idx >= stored_q) begin
                read_idx_q <= '0;
            end else begin
                read_idx_q <= DEPTH_LOG2'(next_idx);
            end
        end
    end

    // Oldest sample sits stored_count entries behind the write pointer
    assign read_addr = wr_ptr - DEPTH_LOG2'(stored_q) + read_idx_q;

    always_comb begin
        status           = '0;
        status.armed     = (state == capture_pkg::st_armed);
        status.triggered = (state == capture_pkg::st_triggered) ||
                           (state == capture_pkg::st_done);
        status.done      = (state == capture_pkg::st_done);
        status.wrapped   = wrapped_q;
    end

    // A completely full 256 entry buffer shows a stored count of 0
    assign read_index   = 8'(read_idx_q);
    assign stored_count = 8'(stored_q);
    assign pre_count    = 8'(pre_q);

endmodule

`default_nettype wire

//--- src/capture_pkg.sv
`default_nettype none

package capture_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample and register bank types
    ////////////////////////////////////////////////////////////////////////////

    // One probe line per bit, read back as two register bytes
    localparam int sample_width = 16;

    typedef logic [sample_width-1:0] sample_t;

    // Current sample and the one before it, for edge checks
    typedef struct packed {
        sample_t current;
        sample_t previous;
    } sample_pair_t;

    // Byte 0 sits in the low bits
    typedef logic [7:0][7:0] reg_bank_t;

    typedef struct packed {
        sample_t    trig_value;
        sample_t    trig_mask;
        sample_t    trig_edge;
        logic [7:0] post_count;
    } capture_cfg_t;

    ////////////////////////////////////////////////////////////////////////////
    // Commands, states and status
    ////////////////////////////////////////////////////////////////////////////

    // Any other opcode byte is ignored
    typedef enum logic [7:0] {
        cmd_arm        = 8'h01,
        cmd_abort      = 8'h02,
        cmd_read_reset = 8'h03,
        cmd_read_next  = 8'h04
    } capture_cmd_e;

    typedef enum logic [1:0] {
        st_idle,
        st_armed,
        st_triggered,
        st_done
    } capture_state_e;

    // Armed in bit 0
    typedef struct packed {
        logic [3:0] spare;
        logic       wrapped;
        logic       done;
        logic       triggered;
        logic       armed;
    } capture_status_t;

    // Input bank
    localparam int reg_trig_value_lo = 0;
    localparam int reg_trig_value_hi = 1;
    localparam int reg_trig_mask_lo  = 2;
    localparam int reg_trig_mask_hi  = 3;
    localparam int reg_trig_edge_lo  = 4;
    localparam int reg_trig_edge_hi  = 5;
    localparam int reg_post_count    = 6;

    // Output bank
    localparam int reg_read_data_lo  = 0;
    localparam int reg_read_data_hi  = 1;
    localparam int reg_live_lo       = 2;
    localparam int reg_live_hi       = 3;
    localparam int reg_read_index    = 4;
    localparam int reg_stored_count  = 5;
    localparam int reg_pre_count     = 6;
    localparam int reg_capture_seq   = 7;

endpackage

`default_nettype wire

//--- src/capture_regs.sv
`timescale 1ns/1ns
`default_nettype none

module capture_regs #(
    parameter int DEPTH_LOG2 = 8
) (
    input  wire capture_pkg::reg_bank_t reg_in,
    output capture_pkg::capture_cfg_t   cfg,
    input  wire capture_pkg::sample_t   live,
    input  wire capture_pkg::sample_t   read_data,
    input  wire  [7:0]                  read_index,
    input  wire  [7:0]                  stored_count,
    input  wire  [7:0]                  pre_count,
    input  wire  [7:0]                  capture_seq,
    output capture_pkg::reg_bank_t      reg_out
);

    // Keeps at least one pre-trigger slot in the buffer
    localparam int post_max = (1 << DEPTH_LOG2) - 2;

    localparam int hi_msb = capture_pkg::sample_width - 1;

    // Configuration words from byte pairs
    always_comb begin
        cfg.trig_value = {reg_in[capture_pkg::reg_trig_value_hi],
                          reg_in[capture_pkg::reg_trig_value_lo]};
        cfg.trig_mask  = {reg_in[capture_pkg::reg_trig_mask_hi],
                          reg_in[capture_pkg::reg_trig_mask_lo]};
        cfg.trig_edge  = {reg_in[capture_pkg::reg_trig_edge_hi],
                          reg_in[capture_pkg::reg_trig_edge_lo]};
        if (int'(reg_in[capture_pkg::reg_post_count]) > post_max) begin
            cfg.post_count = 8'(post_max);
        end else begin
            cfg.post_count = reg_in[capture_pkg::reg_post_count];
        end
    end

    // Output bank
    always_comb begin
        reg_out[capture_pkg::reg_read_data_lo] = read_data[7:0];
        reg_out[capture_pkg::reg_read_data_hi] = read_data[hi_msb:8];
        reg_out[capture_pkg::reg_live_lo]      = live[7:0];
        reg_out[capture_pkg::reg_live_hi]      = live[hi_msb:8];
        reg_out[capture_pkg::reg_read_index]   = read_index;
        reg_out[capture_pkg::reg_stored_count] = stored_count;
        reg_out[capture_pkg::reg_pre_count]    = pre_count;
        reg_out[capture_pkg::reg_capture_seq]  = capture_seq;
    end

endmodule

`default_nettype wire

//--- src/logic_capture_top.sv
`timescale 1ns/1ns
`default_nettype none

module logic_capture_top #(
    parameter int DEPTH_LOG2 = 8
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire capture_pkg::sample_t     sample_async,
    input  wire capture_pkg::reg_bank_t   reg_in,
    output capture_pkg::reg_bank_t        reg_out,
    input  wire                           command_strobe,
    input  wire  [7:0]                    command,
    output capture_pkg::capture_status_t  status
);

    capture_pkg::sample_pair_t   probe_pair;
    capture_pkg::sample_t        store_sample;
    capture_pkg::sample_t        read_data;
    capture_pkg::capture_cfg_t   cfg;
    capture_pkg::capture_state_e state;
    capture_pkg::capture_cmd_e   command_op;
    logic                        trig_hit;
    logic                        wr_en;
    logic [DEPTH_LOG2-1:0]       wr_ptr;
    logic [DEPTH_LOG2-1:0]       read_addr;
    logic [7:0]                  read_index;
    logic [7:0]                  stored_count;
    logic [7:0]                  pre_count;
    logic [7:0]                  capture_seq;

    // Unknown opcodes fall through the controller decode
    assign command_op = capture_pkg::capture_cmd_e'(command);

    ////////////////////////////////////////////////////////////////////////////
    // Probe path
    ////////////////////////////////////////////////////////////////////////////

    probe_sampler probe_sampler_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_async (sample_async),
        .pair         (probe_pair),
        .store_sample (store_sample)
    );

    trigger_match trigger_match_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pair       (probe_pair),
        .trig_value (cfg.trig_value),
        .trig_mask  (cfg.trig_mask),
        .trig_edge  (cfg.trig_edge),
        .state      (state),
        .trig_hit   (trig_hit)
    );

    sample_store #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) sample_store_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_data   (store_sample),
        .read_addr (read_addr),
        .wr_ptr    (wr_ptr),
        .read_data (read_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Control and register map
    ////////////////////////////////////////////////////////////////////////////

    capture_control #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) capture_control_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .command_strobe (command_strobe),
        .command        (command_op),
        .trig_hit       (trig_hit),
        .post_count     (cfg.post_count),
        .wr_ptr         (wr_ptr),
        .wr_en          (wr_en),
        .read_addr      (read_addr),
        .state          (state),
        .status         (status),
        .read_index     (read_index),
        .stored_count   (stored_count),
        .pre_count      (pre_count),
        .capture_seq    (capture_seq)
    );

    capture_regs #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) capture_regs_inst (
        .reg_in       (reg_in),
        .cfg          (cfg),
        .live         (probe_pair.current),
        .read_data    (read_data),
        .read_index   (read_index),
        .stored_count (stored_count),
        .pre_count    (pre_count),
        .capture_seq  (capture_seq),
        .reg_out      (reg_out)
    );

endmodule

`default_nettype wire

//--- src/probe_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module probe_sampler (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire capture_pkg::sample_t sample_async,
    output capture_pkg::sample_pair_t pair,
    output capture_pkg::sample_t      store_sample
);

    capture_pkg::sample_t sync_meta;
    capture_pkg::sample_t sync_q;
    capture_pkg::sample_t prev_q;

    // Two flop synchroniser, then one more stage for the previous sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
            prev_q    <= '0;
        end else begin
            sync_meta <= sample_async;
            sync_q    <= sync_meta;
            prev_q    <= sync_q;
        end
    end

    assign pair.current  = sync_q;
    assign pair.previous = prev_q;

    // Store one stage late so the judged sample lands with its trig_hit
    assign store_sample = prev_q;

endmodule

`default_nettype wire

//--- src/sample_store.sv
`timescale 1ns/1ns
`default_nettype none

module sample_store #(
    parameter int DEPTH_LOG2 = 8
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       wr_en,
    input  wire capture_pkg::sample_t wr_data,
    input  wire  [DEPTH_LOG2-1:0]     read_addr,
    output logic [DEPTH_LOG2-1:0]     wr_ptr,
    output capture_pkg::sample_t      read_data
);

    localparam int depth = 1 << DEPTH_LOG2;

    capture_pkg::sample_t mem [0:depth-1];

    // Write pointer wraps naturally at the power of two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Simple dual port memory with a registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

//--- src/trigger_match.sv
`timescale 1ns/1ns
`default_nettype none

module trigger_match (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire capture_pkg::sample_pair_t pair,
    input  wire capture_pkg::sample_t      trig_value,
    input  wire capture_pkg::sample_t      trig_mask,
    input  wire capture_pkg::sample_t      trig_edge,
    input  var  capture_pkg::capture_state_e state,
    output logic                           trig_hit
);

    capture_pkg::sample_t value_diff;
    capture_pkg::sample_t prev_diff;
    logic                 value_ok;
    logic                 edge_ok;

    // Bits where each sample disagrees with the trigger value
    assign value_diff = pair.current ^ trig_value;
    assign prev_diff  = pair.previous ^ trig_value;

    // Masked bits must all match
    assign value_ok = ((value_diff & trig_mask) == '0);

    // Edge bits must all have been different one sample earlier
    assign edge_ok = ((prev_diff & trig_edge) == trig_edge);

    // Only raised while armed, the controller takes the first one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trig_hit <= 1'b0;
        end else begin
            trig_hit <= (state == capture_pkg::st_armed) && value_ok && edge_ok;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
src/capture_pkg.sv
src/probe_sampler.sv
src/trigger_match.sv
src/sample_store.sv
src/capture_control.sv
src/capture_regs.sv
src/logic_capture_top.sv
verification/tb_logic_capture.sv

//--- verification/tb_logic_capture.sv
`timescale 1ns/1ns
`default_nettype none

module tb_logic_capture;

    localparam int depth_log2 = 6;
    localparam int depth = 1 << depth_log2;

    // Worst case per test is a capture of two buffer lengths plus a full read-back
    localparam int capture_bound = 2 * depth;
    localparam int readback_bound = 3 * depth + 10;
    localparam int timeout_cycles = 2 * (10 + 5 * (capture_bound + readback_bound));

    logic                          clk;
    logic                          rst_n;
    capture_pkg::sample_t          sample_async = '0;
    capture_pkg::reg_bank_t        reg_in;
    capture_pkg::reg_bank_t        reg_out;
    logic                          command_strobe;
    logic [7:0]                    command;
    capture_pkg::capture_status_t  status;

    logic        probe_hold;
    logic [15:0] hold_value;
    logic        first_strobe_seen = 1'b0;
    logic [31:0] lfsr_state = 32'h5ab7;
    logic [15:0] readback [0:depth-1];
    logic [15:0] probe_hist [0:1];
    int          live_cycles = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count;

    logic_capture_top #(
        .DEPTH_LOG2 (depth_log2)
    ) logic_capture_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_async   (sample_async),
        .reg_in         (reg_in),
        .reg_out        (reg_out),
        .command_strobe (command_strobe),
        .command        (command),
        .status         (status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Free-running probe counter, or a held value
    always @(posedge clk) begin
        if (probe_hold) begin
            sample_async <= hold_value;
        end else begin
            sample_async <= sample_async + 16'd1;
        end
    end

    always @(posedge clk) begin
        if (command_strobe) begin
            first_strobe_seen <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [15:0] actual,
                                   input logic [15:0] expected);
        error_count++;
        $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("** Error at %0t: %s", $time, what);
    endtask

    task automatic expect_eq(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
        check_count++;
        assert (actual === expected) else report_mismatch(name, actual, expected);
    endtask

    // Spare bits always low and the whole status byte quiet until the first command
    always @(negedge clk) begin
        if (rst_n) begin
            expect_eq("status.spare", {12'h000, status.spare}, 16'h0000);
            if (!first_strobe_seen) begin
                expect_eq("status", {8'h00, status}, 16'h0000);
            end
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output logic [15:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    // Post count above depth - 2 is saturated by the register map
    function automatic int clamp_post(input int raw);
        return (raw > depth - 2) ? depth - 2 : raw;
    endfunction

    function automatic logic [15:0] out_byte(input int idx);
        return {8'h00, reg_out[idx]};
    endfunction

    function automatic logic [15:0] read_data_word();
        return {reg_out[capture_pkg::reg_read_data_hi], reg_out[capture_pkg::reg_read_data_lo]};
    endfunction

    function automatic logic [15:0] live_word();
        return {reg_out[capture_pkg::reg_live_hi],
                reg_out[capture_pkg::reg_live_lo]};
    endfunction

    // Live registers follow the probe two clocks behind
    always @(negedge clk) begin
        if (!rst_n) begin
            live_cycles = 0;
        end else begin
            if (live_cycles >= 2) begin
                expect_eq("live", live_word(), probe_hist[1]);
            end
            live_cycles++;
        end
        probe_hist[1] = probe_hist[0];
        probe_hist[0] = sample_async;
    end

    //////////////////////////////////////////////////////////////////////////////
    // Bus driving
    //////////////////////////////////////////////////////////////////////////////

    task automatic issue_command(input capture_pkg::capture_cmd_e op);
        @(posedge clk);
        command        <= op;
        command_strobe <= 1'b1;
        @(posedge clk);
        command_strobe <= 1'b0;
        command        <= 8'h00;
    endtask

    // Index moves on the strobe edge and the memory read lands one edge later
    task automatic settle_read();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic set_config(input logic [15:0] value, input logic [15:0] mask,
                              input logic [15:0] edge_bits, input logic [7:0] post);
        capture_pkg::reg_bank_t bank;
        bank = '0;
        bank[capture_pkg::reg_trig_value_lo] = value[7:0];
        bank[capture_pkg::reg_trig_value_hi] = value[15:8];
        bank[capture_pkg::reg_trig_mask_lo]  = mask[7:0];
        bank[capture_pkg::reg_trig_mask_hi]  = mask[15:8];
        bank[capture_pkg::reg_trig_edge_lo]  = edge_bits[7:0];
        bank[capture_pkg::reg_trig_edge_hi]  = edge_bits[15:8];
        bank[capture_pkg::reg_post_count]    = post;
        @(posedge clk);
        reg_in <= bank;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!status.done);
    endtask

    task automatic read_all(input int count);
        int i;
        issue_command(capture_pkg::cmd_read_reset);
        settle_read();
        expect_eq("read_index", out_byte(capture_pkg::reg_read_index), 16'h0000);
        readback[0] = read_data_word();
        for (i = 1; i < count; i++) begin
            issue_command(capture_pkg::cmd_read_next);
            settle_read();
            expect_eq("read_index", out_byte(capture_pkg::reg_read_index), 16'(i));
            readback[i] = read_data_word();
        end
    endtask

    task automatic check_neighbours(input int count);
        int i;
        for (i = 1; i < count; i++) begin
            expect_eq($sformatf("read_data[%0d]", i), readback[i],
                      16'(readback[i-1] + 16'd1));
        end
    endtask

    //////////////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////////////

    task automatic reset_values();
        int i;
        @(negedge clk);
        expect_eq("status", {8'h00, status}, 16'h0000);
        for (i = capture_pkg::reg_read_index; i <= capture_pkg::reg_capture_seq; i++) begin
            expect_eq($sformatf("reg_out[%0d]", i), out_byte(i), 16'h0000);
        end
        repeat (5) @(negedge clk);
    endtask

    task automatic immediate_trigger();
        logic [15:0] raw;
        int          post_eff;
        int          seq_before;
        take_random(6, raw);
        post_eff = clamp_post(int'(raw));
        set_config(16'h0000, 16'h0000, 16'h0000, raw[7:0]);
        @(negedge clk);
        seq_before = int'(reg_out[capture_pkg::reg_capture_seq]);
        issue_command(capture_pkg::cmd_arm);
        wait_done();
        expect_eq("pre_count", out_byte(capture_pkg::reg_pre_count), 16'h0000);
        expect_eq("stored_count", out_byte(capture_pkg::reg_stored_count), 16'(post_eff + 1));
        expect_eq("status.wrapped", {15'h0000, status.wrapped}, 16'h0000);
        expect_eq("capture_seq", out_byte(capture_pkg::reg_capture_seq),
                  16'((seq_before + 1) % 256));
        read_all(post_eff + 1);
        check_neighbours(post_eff + 1);
    endtask

    task automatic value_trigger_with_wrap();
        logic [15:0] raw;
        logic [15:0] offset;
        logic [15:0] value;
        int          post_eff;
        int          seq_before;
        int          pre;
        take_random(6, raw);
        take_random(5, offset);
        post_eff = clamp_post(int'(raw));
        // Far enough ahead that the buffer fills before the match
        value = 16'(sample_async + 16'd100 + offset);
        set_config(value, 16'hffff, 16'h0000, raw[7:0]);
        @(negedge clk);
        seq_before = int'(reg_out[capture_pkg::reg_capture_seq]);
        issue_command(capture_pkg::cmd_arm);
        wait_done();
        pre = depth - 1 - post_eff;
        expect_eq("pre_count", out_byte(capture_pkg::reg_pre_count), 16'(pre));
        expect_eq("stored_count", out_byte(capture_pkg::reg_stored_count), 16'(depth));
        expect_eq("status.wrapped", {15'h0000, status.wrapped}, 16'h0001);
        expect_eq("capture_seq", out_byte(capture_pkg::reg_capture_seq),
                  16'((seq_before + 1) % 256));
        read_all(depth);
        expect_eq("read_data at pre_count", readback[pre], value);
        check_neighbours(depth);
    endtask

    task automatic edge_trigger();
        logic [15:0] raw;
        logic [15:0] value;
        int          post_eff;
        int          pre;
        take_random(16, value);
        take_random(6, raw);
        post_eff = clamp_post(int'(raw));
        @(posedge clk);
        probe_hold <= 1'b1;
        hold_value <= value;
        set_config(value, 16'hffff, 16'hffff, raw[7:0]);
        repeat (4) @(posedge clk);
        issue_command(capture_pkg::cmd_arm);
        repeat (20) @(negedge clk);
        check_count++;
        assert (status.armed && !status.triggered)
            else report_failure("edge trigger fired while the probe held the trigger value");
        // Leave the value on every bit, then come back to it
        @(posedge clk);
        hold_value <= ~value;
        repeat (3) @(posedge clk);
        hold_value <= value;
        wait_done();
        pre = int'(reg_out[capture_pkg::reg_pre_count]);
        expect_eq("stored_count", out_byte(capture_pkg::reg_stored_count),
                  16'(pre + 1 + post_eff));
        read_all(pre + 1 + post_eff);
        expect_eq("read_data at pre_count", readback[pre], value);
        if (pre > 0) begin
            expect_eq("read_data before trigger", readback[pre-1], ~value);
        end else begin
            report_failure("edge capture stored no sample before the trigger");
        end
        @(posedge clk);
        probe_hold <= 1'b0;
    endtask

    task automatic abort_and_read_wrap();
        int i;
        int stored;
        stored = int'(reg_out[capture_pkg::reg_stored_count]);
        issue_command(capture_pkg::cmd_abort);
        @(negedge clk);
        expect_eq("status.done", {15'h0000, status.done}, 16'h0000);
        expect_eq("stored_count", out_byte(capture_pkg::reg_stored_count), 16'(stored));
        issue_command(capture_pkg::cmd_read_reset);
        settle_read();
        expect_eq("read_data", read_data_word(), readback[0]);
        for (i = 0; i < stored; i++) begin
            issue_command(capture_pkg::cmd_read_next);
            settle_read();
            expect_eq("read_index", out_byte(capture_pkg::reg_read_index),
                      16'((i + 1) % stored));
        end
        expect_eq("read_data", read_data_word(), readback[0]);

        // Abort from armed with a value the counter will not reach
        set_config(16'(sample_async + 16'h8000), 16'hffff, 16'h0000, 8'd0);
        issue_command(capture_pkg::cmd_arm);
        repeat (4) @(negedge clk);
        expect_eq("status.armed", {15'h0000, status.armed}, 16'h0001);
        issue_command(capture_pkg::cmd_abort);
        @(negedge clk);
        expect_eq("status[2:0]", {13'h0000, status.done, status.triggered, status.armed},
                  16'h0000);
    endtask

    //////////////////////////////////////////////////////////////////////////////
    // Sequence and run limit
    //////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n          = 1'b0;
        command_strobe = 1'b0;
        command        = 8'h00;
        reg_in         = '0;
        probe_hold     = 1'b0;
        hold_value     = 16'h0000;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        immediate_trigger();
        value_trigger_with_wrap();
        edge_trigger();
        abort_and_read_wrap();
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
